// ==== lsu.f ====
+incdir+source
source/lsuPkg.sv
source/lsuRequestDecode.sv
source/lsuBusFsm.sv
source/lsuReadAlign.sv
source/lsu.sv
dv/lsu_properties.sv
dv/lsuTb.sv

// ==== dv/lsuTb.sv ====
/*
  testbench for the load/store unit
  random requests from a Galois LFSR with a fixed seed
  16-word memory window at a fixed base, answered here with a 0 to 3 cycle ack delay
  the first mismatch or timeout ends the run
*/

`timescale 1ns/1ps

`include "lsu_consts.svh"

module lsuTb import lsuPkg::*; ();

  localparam logic [31:0] Base = 32'h0000_1000;
  localparam int TimeoutCycles = 16;
  localparam int RandomRequests = 400;

  logic                 clk;
  logic                 arstN;
  lsuReqT               req;
  logic                 stallW;
  logic                 flushW;
  logic                 memAck;
  logic [`LSU_XLEN-1:0] hrData;
  busCmdT               bus;
  logic                 dataStall;
  logic                 loadMisaligned;
  logic                 storeMisaligned;
  logic                 squashScW;
  logic [`LSU_XLEN-1:0] readDataW;

  logic [31:0] lfsr;
  // memory answering the bus, and the model's own copy
  logic [31:0] mem [16];
  logic [31:0] shadow [16];
  // model reservation, word index in the window
  logic        resValidM;
  logic [3:0]  resIdxM;
  int          strobeRises = 0;
  logic        strobePrev = 1'b0;

  lsu i_lsu (
    .clk             (clk),
    .arstN           (arstN),
    .req             (req),
    .stallW          (stallW),
    .flushW          (flushW),
    .memAck          (memAck),
    .hrData          (hrData),
    .bus             (bus),
    .dataStall       (dataStall),
    .loadMisaligned  (loadMisaligned),
    .storeMisaligned (storeMisaligned),
    .squashScW       (squashScW),
    .readDataW       (readDataW)
  );

  bind lsu lsuProperties i_lsuProperties (
    .clk    (clk),
    .arstN  (arstN),
    .bus    (bus),
    .memAck (memAck),
    .stallW (stallW)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // bus accesses as strobe rising edges, sampled mid-cycle
  always @(negedge clk) begin
    if ((bus.read | bus.write) && !strobePrev) begin
      strobeRises++;
    end
    strobePrev = bus.read | bus.write;
  end

  // a failed bus protocol assertion ends the run at once
  always @(negedge clk) begin
    if (i_lsu.i_lsuProperties.assertFails != 0) begin
      $display("bus protocol assertion failed at %0t ns", $time);
      $display("TEST FAILED");
      $fatal(1, "assertion failure");
    end
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one LFSR step per bit taken
  function automatic logic [31:0] randomBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsrNext(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // 2**size bytes starting at the offset
  function automatic logic [3:0] laneMask(input logic [1:0] size, input logic [1:0] off);
    return 4'(((1 << (1 << size)) - 1) << off);
  endfunction

  function automatic logic [31:0] byteBits(input logic [3:0] m);
    return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
  endfunction

  // lb, lh, lw, lbu, lhu from the word at the offset
  function automatic logic [31:0] loadValue(input logic [31:0] word, input logic [2:0] f3,
                                            input logic [1:0] off);
    logic [31:0] s;
    s = word >> (8 * off);
    case (f3)
      3'b000:  return {{24{s[7]}}, s[7:0]};
      3'b001:  return {{16{s[15]}}, s[15:0]};
      3'b100:  return {24'd0, s[7:0]};
      3'b101:  return {16'd0, s[15:0]};
      default: return word;
    endcase
  endfunction

  task automatic expectEq(input logic [31:0] actual, input logic [31:0] expected,
                          input string what);
    if (actual !== expected) begin
      $display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
      $display("TEST FAILED");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic nextCycle();
    @(posedge clk);
    #10;
  endtask

  task automatic flushReservation();
    flushW = 1'b1;
    nextCycle();
    flushW = 1'b0;
    resValidM = 1'b0;
  endtask

  //////////////////////////////
  // one request, start to finish
  //////////////////////////////

  task automatic doRequest(input logic rd, input logic wr, input logic [2:0] f3,
                           input logic rsv, input logic [3:0] idx, input logic [1:0] off,
                           input logic [31:0] data, input int ackDelay, input logic stallHold);
    logic        misal;
    logic        scFailM;
    logic        access;
    logic [3:0]  mask;
    logic [31:0] prevRead;
    logic [31:0] expLoad;
    int          rises;
    int          waited;
    mask     = laneMask(f3[1:0], off);
    // size 3 never aligns on RV32
    misal    = (f3[1:0] == 2'd3) || ((off & 2'((1 << f3[1:0]) - 1)) != 2'd0);
    scFailM  = wr & rsv & !(resValidM && resIdxM == idx);
    access   = (rd | wr) & !misal & !scFailM;
    prevRead = readDataW;
    expLoad  = loadValue(shadow[idx], f3, off);
    rises    = strobeRises;
    req.read    = rd;
    req.write   = wr;
    req.funct3  = f3;
    req.reserve = rsv;
    req.addr    = Base | {26'd0, idx, off};
    req.wdata   = data;
    stallW      = access & stallHold;
    #1;
    expectEq(loadMisaligned, rd & misal, "loadMisaligned");
    expectEq(storeMisaligned, wr & misal, "storeMisaligned");
    expectEq(dataStall, access, "dataStall on a new request");
    if (!access) begin
      // consumed at the next edge, bus untouched
      nextCycle();
      expectEq(bus.read | bus.write, 1'b0, "strobe for a request with no access");
      expectEq(squashScW, scFailM, "squashScW");
      expectEq(readDataW, prevRead, "readDataW without a load");
      req = '0;
      if (scFailM) begin
        resValidM = 1'b0;
      end
    end else begin
      waited = 0;
      while (!(bus.read | bus.write)) begin
        if (waited == TimeoutCycles) begin
          $display("timeout at %0t ns: no bus strobe for a legal request", $time);
          $display("TEST FAILED");
          $fatal(1, "no bus strobe");
        end
        nextCycle();
        waited++;
      end
      // strobe comes one cycle after the request
      expectEq(waited, 1, "cycles from request to bus strobe");
      // bus latency
      repeat (ackDelay) begin
        nextCycle();
      end
      expectEq(dataStall, 1'b1, "dataStall while waiting for memAck");
      expectEq(bus.read, rd, "bus read strobe");
      expectEq(bus.write, wr, "bus write strobe");
      expectEq(bus.addr, Base | {26'd0, idx, 2'b00}, "bus word address");
      if (wr) begin
        expectEq(bus.byteEn, mask, "bus byte enables");
        expectEq(bus.wdata & byteBits(mask), (data << (8 * off)) & byteBits(mask),
                 "store lane data");
      end
      memAck = 1'b1;
      hrData = mem[idx];
      for (int b = 0; b < 4; b++) begin
        if (wr && bus.byteEn[b]) begin
          mem[idx][8*b +: 8] = bus.wdata[8*b +: 8];
        end
      end
      #1;
      expectEq(dataStall, 1'b0, "dataStall in the ack cycle");
      nextCycle();
      memAck = 1'b0;
      // readDataW must ignore the bus from here on
      hrData = ~hrData;
      if (!stallHold) begin
        req = '0;
      end
      #1;
      expectEq(readDataW, rd ? expLoad : prevRead, "readDataW after the ack");
      expectEq(bus.read | bus.write, 1'b0, "strobe after the ack");
      expectEq(squashScW, 1'b0, "squashScW for a completed access");
      if (stallHold) begin
        // writeback still stalled, request held but off the bus
        nextCycle();
        expectEq(dataStall, 1'b0, "dataStall while writeback is stalled");
        stallW = 1'b0;
        nextCycle();
        req = '0;
        expectEq(squashScW, 1'b0, "squashScW once writeback resumes");
      end
      for (int b = 0; b < 4; b++) begin
        if (wr && mask[b]) begin
          shadow[idx][8*b +: 8] = data[8*(b - off) +: 8];
        end
      end
      if (rd && rsv) begin
        resValidM = 1'b1;
        resIdxM   = idx;
      end else if (wr && (rsv || resIdxM == idx)) begin
        resValidM = 1'b0;
      end
    end
    nextCycle();
    expectEq(strobeRises - rises, access ? 1 : 0, "bus accesses for one request");
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    logic [1:0]  op;
    logic [2:0]  f3;
    logic [3:0]  idx;
    logic [1:0]  off;
    logic [31:0] data;
    logic        rd;
    logic        rsv;
    lfsr      = 32'h02b8_6bff;
    arstN     = 1'b0;
    req       = '0;
    stallW    = 1'b0;
    flushW    = 1'b0;
    memAck    = 1'b0;
    hrData    = '0;
    resValidM = 1'b0;
    resIdxM   = 4'd0;
    for (int i = 0; i < 16; i++) begin
      mem[i]    = (i + 1) * 32'h9e37_79b1 ^ 32'h5a5a_0f0f;
      shadow[i] = mem[i];
    end
    repeat (5) @(posedge clk);
    #10;
    arstN = 1'b1;
    #1;
    expectEq(bus.read | bus.write, 1'b0, "strobes after reset");
    expectEq(dataStall, 1'b0, "dataStall after reset");
    expectEq(squashScW, 1'b0, "squashScW after reset");
    expectEq(readDataW, 32'd0, "readDataW after reset");
    nextCycle();

    // LR then SC to the same word succeeds, a second SC fails
    doRequest(1'b1, 1'b0, 3'b010, 1'b1, 4'd5, 2'd0, 32'h0, 1, 1'b0);
    doRequest(1'b0, 1'b1, 3'b010, 1'b1, 4'd5, 2'd0, 32'hcafe_0001, 0, 1'b1);
    doRequest(1'b0, 1'b1, 3'b010, 1'b1, 4'd5, 2'd0, 32'hcafe_0002, 0, 1'b0);
    // plain store to the reserved word kills it
    doRequest(1'b1, 1'b0, 3'b010, 1'b1, 4'd7, 2'd0, 32'h0, 0, 1'b0);
    doRequest(1'b0, 1'b1, 3'b000, 1'b0, 4'd7, 2'd2, 32'h0000_00a5, 2, 1'b0);
    doRequest(1'b0, 1'b1, 3'b010, 1'b1, 4'd7, 2'd0, 32'hcafe_0003, 0, 1'b0);
    // so does flushW
    doRequest(1'b1, 1'b0, 3'b010, 1'b1, 4'd9, 2'd0, 32'h0, 3, 1'b1);
    flushReservation();
    doRequest(1'b0, 1'b1, 3'b010, 1'b1, 4'd9, 2'd0, 32'hcafe_0004, 0, 1'b0);

    // flushW at the same edge keeps a failing SC from squashing
    req         = '0;
    req.write   = 1'b1;
    req.funct3  = 3'b010;
    req.reserve = 1'b1;
    req.addr    = Base | {26'd0, 4'd9, 2'd0};
    flushW      = 1'b1;
    nextCycle();
    flushW = 1'b0;
    req    = '0;
    expectEq(squashScW, 1'b0, "squashScW with flushW on a failing SC");
    nextCycle();

    repeat (RandomRequests) begin
      op   = 2'(randomBits(2));
      f3   = 3'(randomBits(3));
      idx  = 4'(randomBits(4));
      off  = 2'(randomBits(2));
      data = randomBits(32);
      rsv  = (op == 2'd3);
      rd   = (op < 2'd2) || (rsv && randomBits(1));
      if (rsv) begin
        // LR and SC are word accesses
        f3  = 3'b010;
        off = 2'd0;
      end
      if (!rd) begin
        f3[2] = 1'b0;
        // aim stores at the reserved word now and then
        if (resValidM && randomBits(1)) begin
          idx = resIdxM;
        end
      end
      if (randomBits(3) == 32'd0) begin
        flushReservation();
      end
      doRequest(rd, !rd, f3, rsv, idx, off, data, int'(randomBits(2)), 1'(randomBits(1)));
    end

    if (i_lsu.i_lsuProperties.assertFails == 0) begin
      $display("TEST OK");
      $finish;
    end else begin
      $display("bus protocol assertions failed during the run");
      $display("TEST FAILED");
      $fatal(1, "assertion failures");
    end
  end

endmodule

// ==== dv/lsu_properties.sv ====
/*
  bus protocol assertions, bound into the load/store unit top
  memAck is expected only while a read or write strobe is high
*/

`timescale 1ns/1ps

module lsuProperties import lsuPkg::*; (
  input logic   clk,
  input logic   arstN,
  input busCmdT bus,
  input logic   memAck,
  input logic   stallW
);

  int   assertFails = 0;
  logic strobe;
  logic ackPending;

  assign strobe = bus.read | bus.write;

  // ack taken under stallW, the request stays held until stallW falls
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ackPending <= 1'b0;
    end else if (memAck && stallW) begin
      ackPending <= 1'b1;
    end else if (!stallW) begin
      ackPending <= 1'b0;
    end
  end

  strobeInReset: assert property (@(posedge clk) !arstN |-> !strobe)
    else begin
      assertFails++;
      $error("bus strobe high during reset");
    end

  bothStrobes: assert property (@(posedge clk) disable iff (!arstN)
    !(bus.read && bus.write))
    else begin
      assertFails++;
      $error("read and write strobes high together");
    end

  // command frozen until the ack
  strobeHeld: assert property (@(posedge clk) disable iff (!arstN)
    (strobe && !memAck) |=> ($stable(bus.read) && $stable(bus.write)))
    else begin
      assertFails++;
      $error("bus strobe dropped before memAck");
    end

  ackNeedsStrobe: assert property (@(posedge clk) disable iff (!arstN)
    memAck |-> strobe)
    else begin
      assertFails++;
      $error("memAck without a bus strobe");
    end

  quietAfterAck: assert property (@(posedge clk) disable iff (!arstN)
    memAck |=> !strobe)
    else begin
      assertFails++;
      $error("bus strobe high in the cycle after memAck");
    end

  noReissue: assert property (@(posedge clk) disable iff (!arstN)
    ackPending |-> !strobe)
    else begin
      assertFails++;
      $error("held request issued again while writeback stalled");
    end

endmodule

// ==== source/lsu.sv ====
/*
  RV32 load/store unit, memory stage of an in-order core
  no MMU, no PMA/PMP, no AMO, no data cache
  bus strobes are held until a one-cycle memAck
  one request in flight, cpu holds req while dataStall or stallW
*/

`timescale 1ns/1ps

`include "lsu_consts.svh"

module lsu import lsuPkg::*; (
  input  logic                 clk,
  input  logic                 arstN,
  input  lsuReqT               req,
  input  logic                 stallW,
  input  logic                 flushW,
  input  logic                 memAck,
  input  logic [`LSU_XLEN-1:0] hrData,
  output busCmdT               bus,
  output logic                 dataStall,
  output logic                 loadMisaligned,
  output logic                 storeMisaligned,
  output logic                 squashScW,
  output logic [`LSU_XLEN-1:0] readDataW
);

  busCmdT  cmd;
  loadFmtT loadFmt;
  logic    scFail;
  logic    accessDone;
  logic    loadCapture;

  // decode, alignment, store lanes and reservation
  lsuRequestDecode i_lsuRequestDecode (
    .clk             (clk),
    .arstN           (arstN),
    .req             (req),
    .flushW          (flushW),
    .accessDone      (accessDone),
    .cmd             (cmd),
    .scFail          (scFail),
    .loadMisaligned  (loadMisaligned),
    .storeMisaligned (storeMisaligned),
    .loadFmt         (loadFmt)
  );

  // one bus access per request
  lsuBusFsm i_lsuBusFsm (
    .clk         (clk),
    .arstN       (arstN),
    .cmd         (cmd),
    .scFail      (scFail),
    .stallW      (stallW),
    .flushW      (flushW),
    .memAck      (memAck),
    .bus         (bus),
    .dataStall   (dataStall),
    .accessDone  (accessDone),
    .loadCapture (loadCapture),
    .squashScW   (squashScW)
  );

  lsuReadAlign i_lsuReadAlign (
    .clk         (clk),
    .arstN       (arstN),
    .loadFmt     (loadFmt),
    .hrData      (hrData),
    .loadCapture (loadCapture),
    .readDataW   (readDataW)
  );

endmodule

// ==== source/lsuReadAlign.sv ====
/*
  load data alignment and writeback register
  hrData is the whole word at the word-aligned bus address
  readDataW only changes on loadCapture
*/

`timescale 1ns/1ps

`include "lsu_consts.svh"

module lsuReadAlign import lsuPkg::*; (
  input  logic                 clk,
  input  logic                 arstN,
  input  loadFmtT              loadFmt,
  input  logic [`LSU_XLEN-1:0] hrData,
  input  logic                 loadCapture,
  output logic [`LSU_XLEN-1:0] readDataW
);

  logic [7:0]           byteSel;
  logic [15:0]          halfSel;
  logic [`LSU_XLEN-1:0] loadData;

  // pick the lane at the byte offset
  assign byteSel = hrData[8*loadFmt.offset +: 8];
  // halves sit on bit 1 of the offset, bit 0 is known clear
  assign halfSel = hrData[16*loadFmt.offset[1] +: 16];

  always_comb begin
    case (loadFmt.size)
      `LSU_SIZE_BYTE: begin
        loadData = loadFmt.zeroExt ? {{(`LSU_XLEN-8){1'b0}}, byteSel}
                                   : {{(`LSU_XLEN-8){byteSel[7]}}, byteSel};
      end
      `LSU_SIZE_HALF: begin
        loadData = loadFmt.zeroExt ? {{(`LSU_XLEN-16){1'b0}}, halfSel}
                                   : {{(`LSU_XLEN-16){halfSel[15]}}, halfSel};
      end
      default: begin
        loadData = hrData;
      end
    endcase
  end

  // writeback result, loaded at the edge ending the ack cycle
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      readDataW <= '0;
    end else if (loadCapture) begin
      readDataW <= loadData;
    end
  end

endmodule

// ==== source/lsuBusFsm.sv ====
/*
  bus access FSM for the load/store unit
  exactly one bus access per request, never re-issued under stallW
  memAck must only come while a strobe is high
*/

`timescale 1ns/1ps

module lsuBusFsm import lsuPkg::*; (
  input  logic   clk,
  input  logic   arstN,
  input  busCmdT cmd,
  input  logic   scFail,
  input  logic   stallW,
  input  logic   flushW,
  input  logic   memAck,
  output busCmdT bus,
  output logic   dataStall,
  output logic   accessDone,
  output logic   loadCapture,
  output logic   squashScW
);

  typedef enum logic [1:0] {
    Ready,
    Fetch,
    Stalled
  } stateT;

  stateT state;
  stateT nextState;
  logic  wanted;

  // decode already dropped misaligned and failing SC requests
  assign wanted = cmd.read | cmd.write;

  //////////////////////////////
  // state machine
  //////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= Ready;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    dataStall = 1'b0;
    case (state)
      Ready: begin
        if (wanted) begin
          nextState = Fetch;
          dataStall = 1'b1;
        end
      end
      Fetch: begin
        // stall drops in the ack cycle so the cpu moves on at that edge
        dataStall = ~memAck;
        if (memAck) begin
          nextState = stallW ? Stalled : Ready;
        end
      end
      Stalled: begin
        // access is done, wait for writeback without touching the bus
        if (!stallW) begin
          nextState = Ready;
        end
      end
      default: begin
        nextState = Ready;
      end
    endcase
  end

  // strobes only while fetching
  always_comb begin
    bus       = cmd;
    bus.read  = cmd.read & (state == Fetch);
    bus.write = cmd.write & (state == Fetch);
  end

  assign accessDone  = memAck & (state == Fetch);
  assign loadCapture = accessDone & bus.read;

  //////////////////////////////
  // SC squash to writeback
  //////////////////////////////

  // in Stalled the held request already finished, so it cannot squash
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      squashScW <= 1'b0;
    end else if (flushW) begin
      squashScW <= 1'b0;
    end else if (!stallW) begin
      squashScW <= scFail & (state != Stalled);
    end
  end

endmodule

// ==== source/lsuRequestDecode.sv ====
/*
  request decode for the load/store unit
  size 3 (doubleword) always counts as misaligned on RV32
  one word reservation for LR/SC; cleared by flushW
  the request must stay stable while dataStall or stallW is high
*/

`timescale 1ns/1ps

`include "lsu_consts.svh"

module lsuRequestDecode import lsuPkg::*; (
  input  logic    clk,
  input  logic    arstN,
  input  lsuReqT  req,
  input  logic    flushW,
  input  logic    accessDone,
  output busCmdT  cmd,
  output logic    scFail,
  output logic    loadMisaligned,
  output logic    storeMisaligned,
  output loadFmtT loadFmt
);

  logic [1:0] size;
  logic       misaligned;
  logic       isLr;
  logic       isSc;
  logic       resMatch;
  logic       storeHit;
  logic       resValid;
  logic [`LSU_PA_BITS-1:`LSU_RES_LSB] resAddr;

  //////////////////////////////
  // size and alignment
  //////////////////////////////

  assign size = req.funct3[1:0];

  always_comb begin
    case (size)
      `LSU_SIZE_BYTE: misaligned = 1'b0;
      `LSU_SIZE_HALF: misaligned = req.addr[0];
      `LSU_SIZE_WORD: misaligned = |req.addr[1:0];
      default:        misaligned = 1'b1;
    endcase
  end

  assign loadMisaligned  = misaligned & req.read;
  assign storeMisaligned = misaligned & req.write;

  //////////////////////////////
  // LR/SC reservation
  //////////////////////////////

  assign isLr     = req.read & req.reserve;
  assign isSc     = req.write & req.reserve;
  // word address compare against the held reservation
  assign resMatch = resValid & (req.addr[`LSU_PA_BITS-1:`LSU_RES_LSB] == resAddr);
  // plain store landing on the reserved word kills it
  assign storeHit = req.write & ~req.reserve & resMatch;
  assign scFail   = isSc & ~resMatch;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      resValid <= 1'b0;
    end else if (flushW) begin
      resValid <= 1'b0;
    end else if (accessDone) begin
      if (isLr) begin
        resValid <= 1'b1;
      end else if (isSc | storeHit) begin
        resValid <= 1'b0;
      end
    end else if (scFail) begin
      // failed SC never reaches the bus, drop the reservation here
      resValid <= 1'b0;
    end
  end

  // reserved word address, taken when an LR completes
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      resAddr <= '0;
    end else if (accessDone & isLr) begin
      resAddr <= req.addr[`LSU_PA_BITS-1:`LSU_RES_LSB];
    end
  end

  //////////////////////////////
  // bus command and lanes
  //////////////////////////////

  always_comb begin
    cmd.read  = req.read & ~misaligned;
    cmd.write = req.write & ~misaligned & ~scFail;
    cmd.addr  = {req.addr[`LSU_PA_BITS-1:2], 2'b00};
    // replicate the subword, byte enables pick the live lanes
    case (size)
      `LSU_SIZE_BYTE: begin
        cmd.wdata  = {4{req.wdata[7:0]}};
        cmd.byteEn = 4'b0001 << req.addr[1:0];
      end
      `LSU_SIZE_HALF: begin
        cmd.wdata  = {2{req.wdata[15:0]}};
        cmd.byteEn = 4'b0011 << req.addr[1:0];
      end
      `LSU_SIZE_WORD: begin
        cmd.wdata  = req.wdata;
        cmd.byteEn = 4'b1111;
      end
      default: begin
        cmd.wdata  = req.wdata;
        cmd.byteEn = 4'b0000;
      end
    endcase
  end

  // read side format, funct3[2] marks lbu/lhu
  assign loadFmt.offset  = req.addr[1:0];
  assign loadFmt.size    = size;
  assign loadFmt.zeroExt = req.funct3[2];

endmodule

// ==== source/lsuPkg.sv ====
/*
  packed structs passed between the load/store unit blocks
  physical address equals the request address, no translation
*/

`include "lsu_consts.svh"

package lsuPkg;

  // cpu memory request, held by the cpu while stalled
  typedef struct packed {
    logic                    read;
    logic                    write;
    logic [2:0]              funct3;
    // LR when reading, SC when writing
    logic                    reserve;
    logic [`LSU_PA_BITS-1:0] addr;
    logic [`LSU_XLEN-1:0]    wdata;
  } lsuReqT;

  // bus command, strobes held until memAck
  typedef struct packed {
    logic                    read;
    logic                    write;
    // always word aligned
    logic [`LSU_PA_BITS-1:0] addr;
    // store data already on its byte lanes
    logic [`LSU_XLEN-1:0]    wdata;
    logic [3:0]              byteEn;
  } busCmdT;

  // what the read path needs to pick the subword
  typedef struct packed {
    logic [1:0] offset;
    logic [1:0] size;
    logic       zeroExt;
  } loadFmtT;

endpackage

// ==== source/lsu_consts.svh ====
/*
  widths and encodings shared by the load/store unit
  RV32 only, so XLEN and the physical address width are both 32
  size codes are funct3[1:0] of the load or store
*/

`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// datapath and address widths
`define LSU_XLEN 32
`define LSU_PA_BITS 32

// lowest address bit compared for an LR/SC reservation (word granule)
`define LSU_RES_LSB 2

// access size, funct3[1:0]
`define LSU_SIZE_BYTE 2'b00
`define LSU_SIZE_HALF 2'b01
`define LSU_SIZE_WORD 2'b10

`endif
